// ==== dv/core_tb.sv ====
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC   = 32'h0;
    localparam int          PROG_LEN   = 24;
    localparam int          RST_CYCLES = 8;
    localparam int          ROM_AW     = 6;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    rv_pkg::wb_t retire;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic        model_done;
    logic        prev_stb;
    logic        prev_ack;
    logic [31:0] prev_adr;

    core_top #(
        .RESET_PC(RESET_PC)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_ack   (wb_ack),
        .retire   (retire)
    );

    instr_rom #(
        .AW   (ROM_AW),
        .SEED (32'hc2b0_9e60)
    ) rom_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .adr   (wb_adr),
        .dat   (wb_dat),
        .ack   (wb_ack)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // RV32I encodings
    function automatic logic [31:0] alu_rr(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // Architectural result of the instruction at pc
    task automatic predict(input logic [31:0] pc, output logic en, output logic [4:0] rd,
                           output logic [31:0] data, output logic [31:0] next_pc);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        if (pc >= PROG_LEN * 4) begin
            report_failure($sformatf("Retire at pc %h is outside the test program", pc));
        end
        ins     = prog[pc[6:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        en      = 1'b0;
        rd      = ins[11:7];
        data    = 32'h0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                en = 1'b1;
                case ({ins[31:25], ins[14:12]})
                    {7'h00, 3'd0}: data = a + b;
                    {7'h20, 3'd0}: data = a - b;
                    {7'h00, 3'd7}: data = a & b;
                    {7'h00, 3'd6}: data = a | b;
                    {7'h00, 3'd4}: data = a ^ b;
                    {7'h00, 3'd2}: data = {31'b0, $signed(a) < $signed(b)};
                    {7'h00, 3'd1}: data = a << b[4:0];
                    {7'h00, 3'd5}: data = a >> b[4:0];
                    default: report_failure("Test program holds an unsupported ALU op");
                endcase
            end
            7'h13: begin
                en   = 1'b1;
                data = a + imm_i;
            end
            7'h37: begin
                en   = 1'b1;
                data = {ins[31:20], ins[19:12], 12'h000};
            end
            7'h6f: begin
                en      = 1'b1;
                data    = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            7'h63: begin
                // funct3 bit 0 selects BNE over BEQ
                if (ins[12] ? (a != b) : (a == b)) begin
                    next_pc = pc + imm_b;
                end
            end
            default: report_failure("Test program holds an unsupported opcode");
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        // Unused words decode as an illegal opcode
        for (int k = 0; k < 2**ROM_AW; k++) begin
            rom_i.mem[k] = {k[24:0], 7'h7f};
        end
        prog[0]  = addi(1, 0, 5);
        prog[1]  = addi(2, 1, -3);
        prog[2]  = alu_rr(0, 0, 3, 1, 2);
        prog[3]  = alu_rr(32, 0, 4, 2, 3);
        prog[4]  = alu_rr(0, 2, 5, 4, 1);
        prog[5]  = lui(6, 'h80000);
        prog[6]  = alu_rr(0, 5, 7, 6, 2);
        prog[7]  = alu_rr(0, 1, 8, 1, 3);
        prog[8]  = alu_rr(0, 4, 9, 8, 7);
        prog[9]  = alu_rr(0, 6, 10, 9, 4);
        prog[10] = alu_rr(0, 7, 11, 10, 3);
        prog[11] = addi(0, 1, 9);
        prog[12] = alu_rr(0, 0, 12, 0, 1);
        prog[13] = branch(0, 12, 1, 12);
        prog[14] = addi(13, 0, 99);
        prog[15] = addi(13, 0, 98);
        prog[16] = branch(1, 1, 12, 8);
        prog[17] = branch(1, 1, 2, 8);
        prog[18] = addi(14, 0, 1);
        prog[19] = jal(15, 8);
        prog[20] = addi(14, 0, 2);
        prog[21] = branch(0, 1, 2, -8);
        prog[22] = alu_rr(0, 0, 16, 15, 15);
        prog[23] = jal(0, 0);
        for (int k = 0; k < PROG_LEN; k++) begin
            rom_i.mem[k] = prog[k];
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (model_done);
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (RST_CYCLES + PROG_LEN * 20) @(posedge clk);
        report_failure("Watchdog expired before the program reached its final jump");
    end

    always @(negedge clk) begin : check_retire
        logic        exp_en;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic [31:0] next_pc;
        if (!rst_n) begin
            m_pc       = RESET_PC;
            model_done = 1'b0;
            for (int k = 0; k < 32; k++) begin
                m_regs[k] = 32'h0;
            end
            assert (!wb_cyc && !retire.valid)
                else report_failure("wb_cyc or retire valid set during reset");
        end else if (retire.valid) begin
            predict(m_pc, exp_en, exp_rd, exp_data, next_pc);
            assert (retire.pc == m_pc)
                else report_mismatch($sformatf("retired pc %h, model pc %h", retire.pc, m_pc));
            assert (retire.rd_enable == exp_en)
                else report_mismatch($sformatf("pc %h rd_enable %b", m_pc, retire.rd_enable));
            if (exp_en) begin
                assert (retire.rd == exp_rd)
                    else report_mismatch($sformatf("pc %h rd %0d, expected %0d",
                                                   m_pc, retire.rd, exp_rd));
                assert (retire.data == exp_data)
                    else report_mismatch($sformatf("pc %h data %h, expected %h",
                                                   m_pc, retire.data, exp_data));
                if (exp_rd != 5'd0) begin
                    m_regs[exp_rd] = exp_data;
                end
            end
            // Jump to itself ends the program
            model_done = (next_pc == m_pc);
            m_pc       = next_pc;
        end
    end

    always @(negedge clk) begin : check_bus
        if (rst_n && prev_stb && !prev_ack) begin
            assert (wb_stb && wb_adr == prev_adr)
                else report_failure("Wishbone stb or adr changed before ack");
        end
        if (rst_n && prev_ack) begin
            assert (!wb_stb)
                else report_failure("Wishbone stb stayed high in the cycle after ack");
        end
        prev_stb = wb_stb;
        prev_ack = wb_ack;
        prev_adr = wb_adr;
    end

endmodule

`default_nettype wire

// ==== dv/instr_rom.sv ====
`default_nettype none

module instr_rom #(
    parameter int          AW   = 6,
    parameter logic [31:0] SEED = 32'h1
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cyc,
    input  wire         stb,
    input  wire  [31:0] adr,
    output logic [31:0] dat,
    output logic        ack
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [2**AW];
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_1;
    logic [31:0] lfsr_2;
    logic [1:0]  wait_q;
    logic        busy_q;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    assign lfsr_1 = lfsr_next(lfsr_q);
    assign lfsr_2 = lfsr_next(lfsr_1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            busy_q <= 1'b0;
            wait_q <= 2'd0;
            dat    <= 32'h0;
            lfsr_q <= SEED;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy_q) begin
                    // Two LFSR bits give 0 to 3 wait states
                    busy_q <= 1'b1;
                    wait_q <= {lfsr_1[0], lfsr_q[0]};
                    lfsr_q <= lfsr_2;
                end else if (wait_q == 2'd0) begin
                    busy_q <= 1'b0;
                    ack    <= 1'b1;
                    dat    <= mem[adr[AW+1:2]];
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module core_tb -f verilog.f -o core_sim \
    && ./obj_dir/core_sim 2>&1 | tee /dev/stderr | grep -q "all tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== src/core_top.sv ====
`default_nettype none

module core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic [rv_pkg::XLEN-1:0]   wb_adr,
    input  wire  [rv_pkg::XLEN-1:0]   wb_dat_i,
    input  wire                       wb_ack,
    output rv_pkg::wb_t               retire
);

    rv_pkg::stall_t                  stall;
    logic                            flush;
    logic                            redirect;
    logic [rv_pkg::XLEN-1:0]         redirect_pc;
    rv_pkg::if_id_t                  if_id;
    rv_pkg::id_ex_t                  id_dec;
    rv_pkg::id_ex_t                  id_ex_q;
    logic [rv_pkg::REG_ADDR_W-1:0]   rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0]   rs2_addr;
    logic [rv_pkg::XLEN-1:0]         rs1_data;
    logic [rv_pkg::XLEN-1:0]         rs2_data;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .if_id       (if_id)
    );

    decoder decoder_i (
        .if_id    (if_id),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire),
        .id_out   (id_dec)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire)
    );

    id_ex id_ex_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .id_in  (id_dec),
        .ex_out (id_ex_q)
    );

    exec_unit exec_i (
        .ex_in       (id_ex_q),
        .wb          (retire),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pipe_ctrl ctrl_i (
        .if_valid (if_id.valid),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush)
    );

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`default_nettype none

module decoder (
    input  rv_pkg::if_id_t                  if_id,
    output logic [rv_pkg::REG_ADDR_W-1:0]   rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0]   rs2_addr,
    input  wire  [rv_pkg::XLEN-1:0]         rs1_data,
    input  wire  [rv_pkg::XLEN-1:0]         rs2_data,
    input  rv_pkg::wb_t                     wb,
    output rv_pkg::id_ex_t                  id_out
);

    logic [31:0]             instr;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] fwd1;
    logic [rv_pkg::XLEN-1:0] fwd2;
    logic                    legal;
    rv_pkg::id_ex_t          dec;

    assign instr    = if_id.instr;
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Result in execute wins over the register file
    assign fwd1 = (wb.valid && wb.rd_enable && wb.rd == rs1_addr && rs1_addr != '0) ?
                  wb.data : rs1_data;
    assign fwd2 = (wb.valid && wb.rd_enable && wb.rd == rs2_addr && rs2_addr != '0) ?
                  wb.data : rs2_data;

    always_comb begin
        dec      = '0;
        legal    = 1'b1;
        dec.pc   = if_id.pc;
        dec.reg1 = fwd1;
        dec.reg2 = fwd2;
        dec.rd   = instr[11:7];

        case (rv_pkg::opcode_e'(instr[6:0]))
            rv_pkg::OPC_OP: begin
                dec.rd_enable = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.alu_op = rv_pkg::ALU_ADD;
                    {7'h20, 3'b000}: dec.alu_op = rv_pkg::ALU_SUB;
                    {7'h00, 3'b111}: dec.alu_op = rv_pkg::ALU_AND;
                    {7'h00, 3'b110}: dec.alu_op = rv_pkg::ALU_OR;
                    {7'h00, 3'b100}: dec.alu_op = rv_pkg::ALU_XOR;
                    {7'h00, 3'b010}: dec.alu_op = rv_pkg::ALU_SLT;
                    {7'h00, 3'b001}: dec.alu_op = rv_pkg::ALU_SLL;
                    {7'h00, 3'b101}: dec.alu_op = rv_pkg::ALU_SRL;
                    default:         legal = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                // Only ADDI, immediate rides in as operand b
                legal         = (funct3 == 3'b000);
                dec.rd_enable = 1'b1;
                dec.alu_op    = rv_pkg::ALU_ADD;
                dec.imm       = imm_i;
                dec.reg2      = imm_i;
            end
            rv_pkg::OPC_LUI: begin
                dec.rd_enable = 1'b1;
                dec.alu_op    = rv_pkg::ALU_PASS_B;
                dec.imm       = imm_u;
                dec.reg1      = '0;
                dec.reg2      = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                dec.rd_enable = 1'b1;
                dec.jump_op   = rv_pkg::JAL;
                dec.imm       = imm_j;
                dec.jump_addr = if_id.pc + imm_j;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.jump_addr = if_id.pc + imm_b;
                case (funct3)
                    3'b000:  dec.branch_op = rv_pkg::BEQ;
                    3'b001:  dec.branch_op = rv_pkg::BNE;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase

        dec.valid = if_id.valid && legal;
        if (!dec.valid) begin
            dec = '0;
        end
        id_out = dec;
    end

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
`default_nettype none

module exec_unit (
    input  rv_pkg::id_ex_t              ex_in,
    output rv_pkg::wb_t                 wb,
    output logic                        redirect,
    output logic [rv_pkg::XLEN-1:0]     redirect_pc
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] link;
    logic                    is_jal;
    logic                    taken;

    // Operand b already chosen by decode (rs2 or immediate)
    assign op_a = ex_in.reg1;
    assign op_b = ex_in.reg2;

    always_comb begin
        case (ex_in.alu_op)
            rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex_in.branch_op)
            rv_pkg::BEQ: taken = (ex_in.reg1 == ex_in.reg2);
            rv_pkg::BNE: taken = (ex_in.reg1 != ex_in.reg2);
            default:     taken = 1'b0;
        endcase
    end

    assign is_jal = (ex_in.jump_op == rv_pkg::JAL);
    assign link   = ex_in.pc + 32'd4;

    // Bubbles are all zero, so valid gates everything
    assign redirect    = ex_in.valid && (is_jal || taken);
    assign redirect_pc = ex_in.jump_addr;

    always_comb begin
        wb.valid     = ex_in.valid;
        wb.pc        = ex_in.pc;
        wb.rd        = ex_in.rd;
        wb.rd_enable = ex_in.valid && ex_in.rd_enable;
        wb.data      = is_jal ? link : alu_res;
    end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`default_nettype none

module fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  rv_pkg::stall_t            stall,
    input  wire                       redirect,
    input  wire  [rv_pkg::XLEN-1:0]   redirect_pc,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic [rv_pkg::XLEN-1:0]   wb_adr,
    input  wire  [rv_pkg::XLEN-1:0]   wb_dat_i,
    input  wire                       wb_ack,
    output rv_pkg::if_id_t            if_id
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    logic                    stale_q;
    logic                    ack_ok;
    logic                    if_valid_q;
    logic [rv_pkg::XLEN-1:0] if_pc_q;
    logic [31:0]             if_instr_q;

    // Fetch was for the current path and its data is kept
    assign ack_ok = wb_cyc && wb_ack && !stale_q;
    assign wb_stb = wb_cyc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc  <= 1'b0;
            stale_q <= 1'b0;
            wb_adr  <= RESET_PC;
            pc_q    <= RESET_PC;
        end else begin
            if (wb_cyc) begin
                if (wb_ack) begin
                    wb_cyc  <= 1'b0;
                    stale_q <= 1'b0;
                end else if (redirect) begin
                    stale_q <= 1'b1;
                end
            end else if (!stall.fetch) begin
                // New cycle, stb low for at least one cycle after ack
                wb_cyc <= 1'b1;
                wb_adr <= redirect ? redirect_pc : pc_q;
            end

            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (ack_ok) begin
                pc_q <= wb_adr + 32'd4;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_valid_q <= 1'b0;
        end else if (redirect) begin
            if_valid_q <= 1'b0;
        end else if (!stall.fetch) begin
            if_valid_q <= ack_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_ok && !stall.fetch) begin
            if_pc_q    <= wb_adr;
            if_instr_q <= wb_dat_i;
        end
    end

    always_comb begin
        if_id.valid = if_valid_q;
        if_id.pc    = if_pc_q;
        if_id.instr = if_instr_q;
    end

endmodule

`default_nettype wire

// ==== src/id_ex.sv ====
`default_nettype none

module id_ex (
    input  wire                 clk,
    input  wire                 rst_n,
    input  rv_pkg::stall_t      stall,
    input  wire                 flush,
    input  rv_pkg::id_ex_t      id_in,
    output rv_pkg::id_ex_t      ex_out
);

    logic load_bubble;

    // Decode has nothing to hand over but execute keeps moving
    assign load_bubble = flush || (stall.decode && !stall.exec);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_out <= '0;
        end else if (load_bubble) begin
            ex_out <= '0;
        end else if (!stall.exec) begin
            ex_out <= id_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/pipe_ctrl.sv ====
`default_nettype none

module pipe_ctrl (
    input  wire             if_valid,
    input  wire             redirect,
    output rv_pkg::stall_t  stall,
    output logic            flush
);

    always_comb begin
        // No multi-cycle ops or data memory behind execute
        stall.exec   = 1'b0;
        // Nothing fetched yet, so decode waits for the ack
        stall.decode = !if_valid;
        // Fetch never waits on a later stage
        stall.fetch  = 1'b0;
    end

    assign flush = redirect;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]   rs1_addr,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]   rs2_addr,
    output logic [rv_pkg::XLEN-1:0]         rs1_data,
    output logic [rv_pkg::XLEN-1:0]         rs2_data,
    input  rv_pkg::wb_t                     wb
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd_enable && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end

        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        ALU_NONE   = 4'd0,
        ALU_ADD    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_AND    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SLT    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_PASS_B = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BEQ     = 2'd1,
        BNE     = 2'd2
    } branch_op_e;

    typedef enum logic {
        JMP_NONE = 1'b0,
        JAL      = 1'b1
    } jump_op_e;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    // All zero is a bubble
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       reg1;
        logic [XLEN-1:0]       reg2;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_enable;
        alu_op_e               alu_op;
        branch_op_e            branch_op;
        jump_op_e              jump_op;
        logic [XLEN-1:0]       jump_addr;
    } id_ex_t;

    typedef struct packed {
        logic fetch;
        logic decode;
        logic exec;
    } stall_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_enable;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// ==== verilog.f ====
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decoder.sv
src/id_ex.sv
src/exec_unit.sv
src/pipe_ctrl.sv
src/core_top.sv
dv/instr_rom.sv
dv/core_tb.sv
